// File: build.f
+incdir+hdl
hdl/ch_est_pkg.sv
hdl/mult_ctl_if.sv
hdl/mult_sequencer.sv
hdl/re_addr_gen.sv
hdl/sel_seq_lane.sv
hdl/est_out_ctrl.sv
hdl/ch_est_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_ch_est_ctrl.sv

// File: hdl/ch_est_ctrl_top.sv
// top of the NRS channel estimator control unit, ties sequencer, addressing and output selects
`timescale 1ns/100ps
`include "ch_est_defs.svh"

module ch_est_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          demap_ready,
    input  logic                          nrs_gen_ready,
    input  logic [2:0]                    v_shift,
    output ch_est_pkg::col_t              col,
    output logic [1:0]                    nrs_index_addr,
    output logic                          demap_read,
    output logic                          est_ack_nrs,
    output logic                          est_ack_demap,
    output logic [`CH_EST_NRS_ADDR_W-1:0] rd_addr_nrs,
    output logic                          valid_eqlz,
    output logic [1:0]                    addr_mem,
    output logic                          mult_mem_en,
    output logic                          avg_mem_en,
    output ch_est_pkg::sel_code_t         s_h1,
    output ch_est_pkg::sel_code_t         s_h2,
    output logic                          s_est
);

    logic                     est_set_ready;
    ch_est_pkg::shift_class_t est_class;
    ch_est_pkg::sel_code_t    lane_sel [0:`CH_EST_NUM_LANES-1];

    mult_ctl_if u_ctl_if ();

    // ================================================
    // multiply phase
    // ================================================

    mult_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .v_shift       (v_shift),
        .demap_ready   (demap_ready),
        .nrs_gen_ready (nrs_gen_ready),
        .ctl           (u_ctl_if),
        .demap_read    (demap_read),
        .est_ack_nrs   (est_ack_nrs),
        .est_ack_demap (est_ack_demap),
        .mult_mem_en   (mult_mem_en),
        .avg_mem_en    (avg_mem_en),
        .addr_mem      (addr_mem),
        .est_set_ready (est_set_ready),
        .est_class     (est_class)
    );

    re_addr_gen u_addr (
        .clk            (clk),
        .rst            (rst),
        .ctl            (u_ctl_if),
        .col            (col),
        .nrs_index_addr (nrs_index_addr),
        .rd_addr_nrs    (rd_addr_nrs)
    );

    // ================================================
    // output phase
    // ================================================

    // lane 0 feeds s_h1, lane 1 feeds s_h2
    for (genvar i = 0; i < `CH_EST_NUM_LANES; i++) begin : g_lane
        sel_seq_lane #(
            .LANE (i)
        ) u_lane (
            .clk           (clk),
            .rst           (rst),
            .est_set_ready (est_set_ready),
            .est_class     (est_class),
            .sel           (lane_sel[i])
        );
    end

    est_out_ctrl u_out (
        .clk           (clk),
        .rst           (rst),
        .est_set_ready (est_set_ready),
        .est_class     (est_class),
        .lane_sel      (lane_sel),
        .valid_eqlz    (valid_eqlz),
        .s_h1          (s_h1),
        .s_h2          (s_h2),
        .s_est         (s_est)
    );

endmodule

// File: hdl/ch_est_defs.svh
// shared widths and lengths for the NRS channel estimator control, included by RTL and testbench
`ifndef CH_EST_DEFS_SVH
`define CH_EST_DEFS_SVH

// width of the NRS read address
`define CH_EST_NRS_ADDR_W 4

// entries in one output-mux select sequence
`define CH_EST_SEQ_ENTRIES 6

// bits per select code
`define CH_EST_SEL_W 2

// reads per multiply burst
`define CH_EST_BURST_LEN 2

// output-mux select lanes, s_h1 and s_h2
`define CH_EST_NUM_LANES 2

`endif

// File: hdl/ch_est_pkg.sv
// types, pilot column table and select sequence tables shared by the estimator control blocks
`include "ch_est_defs.svh"

package ch_est_pkg;

    // ================================================
    // types
    // ================================================

    // multiply FSM, encodings kept from the older controller
    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        MULT_STORE = 2'b01,
        MULT_ADD   = 2'b11
    } mult_state_t;

    // bit 0 doubles as the estimate-mux select
    typedef enum logic [1:0] {
        SHIFT_0 = 2'd0,
        SHIFT_1 = 2'd1,
        SHIFT_2 = 2'd2
    } shift_class_t;

    typedef logic [`CH_EST_SEL_W-1:0] sel_code_t;
    typedef logic [`CH_EST_SEQ_ENTRIES*`CH_EST_SEL_W-1:0] sel_seq_t;
    typedef logic [3:0] col_t;

    // ================================================
    // tables
    // ================================================

    // OFDM symbols carrying NRS in a subframe
    localparam col_t PILOT_COLS [0:3] = '{4'd5, 4'd6, 4'd12, 4'd13};

    // [lane][class], entry 0 in the low bits
    // lane 0 drives s_h1, lane 1 drives s_h2
    localparam sel_seq_t SEL_SEQ_TABLE [0:`CH_EST_NUM_LANES-1][0:2] = '{
        '{12'b00_01_11_10_01_01, 12'b10_01_01_00_01_01, 12'b11_10_11_11_00_11},
        '{12'b00_10_11_00_10_01, 12'b00_10_11_10_10_01, 12'b11_00_00_01_00_00}
    };

    // v_shift mod 3 without a divider
    function automatic shift_class_t classify_shift(input logic [2:0] v_shift);
        shift_class_t cls;
        case (v_shift)
            3'd0, 3'd3: cls = SHIFT_0;
            3'd1, 3'd4: cls = SHIFT_1;
            default:    cls = SHIFT_2;
        endcase
        return cls;
    endfunction

endpackage

// File: hdl/est_out_ctrl.sv
// equalizer valid window, estimate-mux select and routing of the lane selects to the output muxes
`timescale 1ns/100ps
`include "ch_est_defs.svh"

module est_out_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     est_set_ready,
    input  ch_est_pkg::shift_class_t est_class,
    input  ch_est_pkg::sel_code_t    lane_sel [0:`CH_EST_NUM_LANES-1],
    output logic                     valid_eqlz,
    output ch_est_pkg::sel_code_t    s_h1,
    output ch_est_pkg::sel_code_t    s_h2,
    output logic                     s_est
);

    localparam int WIN_W = $clog2(`CH_EST_SEQ_ENTRIES + 1);

    logic [WIN_W-1:0] win_cnt;
    logic             s_est_q;

    // ================================================
    // valid window
    // ================================================

    // one count per sequence entry
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            win_cnt <= '0;
        end else if (est_set_ready) begin
            win_cnt <= WIN_W'(`CH_EST_SEQ_ENTRIES);
        end else if (win_cnt != '0) begin
            win_cnt <= win_cnt - 1'b1;
        end
    end

    assign valid_eqlz = (win_cnt != '0);

    // ================================================
    // mux selects
    // ================================================

    // class 1 swaps the estimate pairs between out muxes
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s_est_q <= 1'b0;
        end else if (est_set_ready) begin
            s_est_q <= est_class[0];
        end
    end

    assign s_est = s_est_q;
    assign s_h1  = lane_sel[0];
    assign s_h2  = lane_sel[1];

    // next set may only land once the window has drained
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
        est_set_ready |-> (win_cnt == '0));

endmodule

// File: hdl/mult_ctl_if.sv
// multiply-phase control bundle, driven by the sequencer and read by the address generator
`timescale 1ns/100ps

interface mult_ctl_if;

    // burst kind, one-hot or both low in idle
    logic       store_active;
    logic       add_active;
    // reads so far, wraps mod 4
    logic [1:0] burst_cnt;
    // last read of the second burst of a slot
    logic       slot_done;

    modport seq (
        output store_active, add_active, burst_cnt, slot_done
    );

    modport addr (
        input store_active, add_active, burst_cnt, slot_done
    );

endinterface

// File: hdl/mult_sequencer.sv
// slot-pair multiply FSM, drives the read bursts, memory enables, acks and estimate-ready pulse
`timescale 1ns/100ps
`include "ch_est_defs.svh"

module mult_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [2:0]               v_shift,
    input  logic                     demap_ready,
    input  logic                     nrs_gen_ready,
    mult_ctl_if.seq                  ctl,
    output logic                     demap_read,
    output logic                     est_ack_nrs,
    output logic                     est_ack_demap,
    output logic                     mult_mem_en,
    output logic                     avg_mem_en,
    output logic [1:0]               addr_mem,
    output logic                     est_set_ready,
    output ch_est_pkg::shift_class_t est_class
);

    ch_est_pkg::mult_state_t  state, state_nxt;
    ch_est_pkg::shift_class_t class_q;
    logic [1:0] burst_cnt;
    logic       first_slot;
    logic       burst_active;
    logic       burst_last;
    logic       slot_done;

    // ================================================
    // state register and next state
    // ================================================

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ch_est_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // odd count marks the second read of a burst
    assign burst_active = (state != ch_est_pkg::IDLE);
    assign burst_last   = burst_cnt[0];
    assign slot_done    = burst_active && (burst_cnt == 2'd3);

    always_comb begin
        state_nxt = state;
        case (state)
            ch_est_pkg::IDLE: begin
                // wait for both producers
                if (demap_ready && nrs_gen_ready) begin
                    state_nxt = first_slot ? ch_est_pkg::MULT_STORE : ch_est_pkg::MULT_ADD;
                end
            end
            ch_est_pkg::MULT_STORE,
            ch_est_pkg::MULT_ADD: begin
                if (burst_last) begin
                    state_nxt = ch_est_pkg::IDLE;
                end
            end
            default: state_nxt = ch_est_pkg::IDLE;
        endcase
    end

    // ================================================
    // counters and flags
    // ================================================

    // free-running over bursts, idle freezes it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            burst_cnt <= 2'd0;
        end else if (burst_active) begin
            burst_cnt <= burst_cnt + 2'd1;
        end
    end

    // store slot first, add slot second
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            first_slot <= 1'b1;
        end else if (slot_done) begin
            first_slot <= ~first_slot;
        end
    end

    // class held for the whole output window
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            class_q <= ch_est_pkg::SHIFT_0;
        end else if (est_set_ready) begin
            class_q <= ch_est_pkg::classify_shift(v_shift);
        end
    end

    // ================================================
    // outputs, decoded from state in the same cycle
    // ================================================

    assign demap_read    = burst_active;
    assign est_ack_nrs   = burst_active;
    assign mult_mem_en   = (state == ch_est_pkg::MULT_STORE);
    assign avg_mem_en    = (state == ch_est_pkg::MULT_ADD);
    assign addr_mem      = burst_cnt;
    // third estimate written, full set available
    assign est_set_ready = (state == ch_est_pkg::MULT_ADD) && (burst_cnt == 2'd2);
    assign est_ack_demap = est_set_ready;
    // lanes load on this edge, so pass the fresh class through
    assign est_class     = est_set_ready ? ch_est_pkg::classify_shift(v_shift) : class_q;

    assign ctl.store_active = mult_mem_en;
    assign ctl.add_active   = avg_mem_en;
    assign ctl.burst_cnt    = burst_cnt;
    assign ctl.slot_done    = slot_done;

    // ================================================
    // checks
    // ================================================

    // burst kind follows the slot flag, so store and add never mix within a slot
    a_burst_kind_slot: assert property (@(posedge clk) disable iff (!rst)
        burst_active |-> (ctl.store_active == first_slot) && (ctl.add_active == !first_slot));

    a_burst_len: assert property (@(posedge clk) disable iff (!rst)
        $rose(burst_active) |-> burst_active [*`CH_EST_BURST_LEN] ##1 !burst_active);

endmodule

// File: hdl/re_addr_gen.sv
// demapper pilot column walk and NRS index and read addresses, stepped by multiply bursts
`timescale 1ns/100ps
`include "ch_est_defs.svh"

module re_addr_gen (
    input  logic                          clk,
    input  logic                          rst,
    mult_ctl_if.addr                      ctl,
    output ch_est_pkg::col_t              col,
    output logic [1:0]                    nrs_index_addr,
    output logic [`CH_EST_NRS_ADDR_W-1:0] rd_addr_nrs
);

    logic [1:0] col_ptr;
    logic       rd_active;

    assign rd_active = ctl.store_active || ctl.add_active;

    // ================================================
    // column walk
    // ================================================

    // one pilot column per burst, wraps after 13
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            col_ptr <= 2'd0;
        end else if (rd_active && ctl.burst_cnt[0]) begin
            col_ptr <= col_ptr + 2'd1;
        end
    end

    assign col = ch_est_pkg::PILOT_COLS[col_ptr];

    // ================================================
    // NRS addresses
    // ================================================

    // index gen turns this into the demapper row
    // NRS memory holds two words per read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            nrs_index_addr <= 2'd0;
            rd_addr_nrs    <= '0;
        end else if (rd_active) begin
            nrs_index_addr <= nrs_index_addr + 2'd1;
            rd_addr_nrs    <= rd_addr_nrs + `CH_EST_NRS_ADDR_W'(2);
        end
    end

    // a slot ends on its second column, odd pointer
    a_slot_col_align: assert property (@(posedge clk) disable iff (!rst)
        ctl.slot_done |-> col_ptr[0]);

endmodule

// File: hdl/sel_seq_lane.sv
// one output-mux select lane, loads its class sequence and plays one entry per cycle
`timescale 1ns/100ps
`include "ch_est_defs.svh"

module sel_seq_lane #(
    parameter int LANE = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     est_set_ready,
    input  ch_est_pkg::shift_class_t est_class,
    output ch_est_pkg::sel_code_t    sel
);

    ch_est_pkg::sel_seq_t seq_q;

    // ================================================
    // sequence shift register
    // ================================================

    // load on the ready pulse, entry 0 shows next cycle
    // zeros shift in behind the last entry
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            seq_q <= '0;
        end else if (est_set_ready) begin
            seq_q <= ch_est_pkg::SEL_SEQ_TABLE[LANE][est_class];
        end else begin
            seq_q <= seq_q >> `CH_EST_SEL_W;
        end
    end

    // current entry
    assign sel = seq_q[`CH_EST_SEL_W-1:0];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_ch_est_ctrl -o tb_sim
output="$(./obj_dir/tb_sim)"
echo "$output"
if grep -Fxq "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_ch_est_ctrl.sv
// testbench for the channel estimator control top, drives readies and v_shift, checks every cycle
`timescale 1ns/100ps
`include "ch_est_defs.svh"

module tb_ch_est_ctrl;

    // ================================================
    // run limits and DUT signals
    // ================================================

    localparam int RAND_PAIRS     = 6;
    // reset test, one pair, eight sweep pairs, random pairs
    localparam int PLANNED_BURSTS = 4 + 8 * 4 + RAND_PAIRS * 4;
    localparam int CYCLE_LIMIT    = 40 * PLANNED_BURSTS + 100;
    localparam int SEQ            = `CH_EST_SEQ_ENTRIES;

    typedef struct packed {
        logic                          demap_read;
        logic                          est_ack_nrs;
        logic                          est_ack_demap;
        logic                          mult_mem_en;
        logic                          avg_mem_en;
        logic [1:0]                    addr_mem;
        ch_est_pkg::col_t              col;
        logic [1:0]                    nrs_index_addr;
        logic [`CH_EST_NRS_ADDR_W-1:0] rd_addr_nrs;
        logic                          valid_eqlz;
        ch_est_pkg::sel_code_t         s_h1;
        ch_est_pkg::sel_code_t         s_h2;
        logic                          s_est;
    } exp_t;

    logic clk, rst;
    logic demap_ready, nrs_gen_ready;
    logic [2:0] v_shift;
    ch_est_pkg::col_t col;
    logic [1:0] nrs_index_addr, addr_mem;
    logic demap_read, est_ack_nrs, est_ack_demap, valid_eqlz;
    logic mult_mem_en, avg_mem_en, s_est;
    logic [`CH_EST_NRS_ADDR_W-1:0] rd_addr_nrs;
    ch_est_pkg::sel_code_t s_h1, s_h2;

    // reference model state, owned by the compare process
    bit m_active, est_sel;
    int m_beat, m_burst, beats_done, win_left, win_cls;
    int errors, checks, windows_seen, cycles;
    int tests_run, tests_failed, test_err0, test_win0;
    string test_name;
    logic [31:0] lcg_state;
    exp_t e;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(4)) u_clk (.clk(clk), .rst(rst));

    ch_est_ctrl_top DUT (
        .clk(clk), .rst(rst), .demap_ready(demap_ready), .nrs_gen_ready(nrs_gen_ready),
        .v_shift(v_shift), .col(col), .nrs_index_addr(nrs_index_addr),
        .demap_read(demap_read), .est_ack_nrs(est_ack_nrs), .est_ack_demap(est_ack_demap),
        .rd_addr_nrs(rd_addr_nrs), .valid_eqlz(valid_eqlz), .addr_mem(addr_mem),
        .mult_mem_en(mult_mem_en), .avg_mem_en(avg_mem_en), .s_h1(s_h1), .s_h2(s_h2),
        .s_est(s_est)
    );

    // ================================================
    // reference model
    // ================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // 0 and 3 share a class, 1 and 4 share one, everything else is class 2
    function automatic int shift_class(input logic [2:0] v);
        if (v == 3'd0 || v == 3'd3)
            return 0;
        else if (v == 3'd1 || v == 3'd4)
            return 1;
        return 2;
    endfunction

    function automatic ch_est_pkg::col_t pilot_col(input int idx);
        ch_est_pkg::col_t c;
        case (idx)
            0:       c = 4'd5;
            1:       c = 4'd6;
            2:       c = 4'd12;
            default: c = 4'd13;
        endcase
        return c;
    endfunction

    function automatic ch_est_pkg::sel_code_t seq_entry(input int lane, input int cls,
                                                        input int idx);
        ch_est_pkg::sel_seq_t s;
        s = ch_est_pkg::SEL_SEQ_TABLE[lane][cls];
        return s[idx*`CH_EST_SEL_W +: `CH_EST_SEL_W];
    endfunction

    // expected outputs for one cycle from position in the slot pair and window
    function automatic exp_t ref_outputs(input bit active, input int beat, input int burst,
                                         input int done, input int left, input int cls,
                                         input bit sel);
        exp_t r;
        r                = '0;
        r.demap_read     = active;
        r.est_ack_nrs    = active;
        // STORE, STORE, ADD, ADD
        r.mult_mem_en    = active && (burst < 2);
        r.avg_mem_en     = active && (burst >= 2);
        // first beat of the last add burst
        r.est_ack_demap  = active && (burst == 3) && (beat == 0);
        r.addr_mem       = 2'(done % 4);
        r.nrs_index_addr = 2'(done % 4);
        r.rd_addr_nrs    = `CH_EST_NRS_ADDR_W'((2 * done) % (1 << `CH_EST_NRS_ADDR_W));
        r.col            = pilot_col((done / 2) % 4);
        r.valid_eqlz     = (left > 0);
        if (left > 0) begin
            r.s_h1 = seq_entry(0, cls, SEQ - left);
            r.s_h2 = seq_entry(1, cls, SEQ - left);
        end
        r.s_est          = sel;
        return r;
    endfunction

    // ================================================
    // compare tasks
    // ================================================

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @ %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_col(input ch_est_pkg::col_t got, input ch_est_pkg::col_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @ %0t: col got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input ch_est_pkg::sel_code_t got,
                             input ch_est_pkg::sel_code_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @ %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`CH_EST_NRS_ADDR_W-1:0] got,
                              input logic [`CH_EST_NRS_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @ %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // outputs settle by the falling edge, inputs seen here are what the next rising edge uses
    always @(negedge clk) begin
        if (rst) begin
            e = ref_outputs(m_active, m_beat, m_burst, beats_done, win_left, win_cls, est_sel);
            check_flag("demap_read", demap_read, e.demap_read);
            check_flag("est_ack_nrs", est_ack_nrs, e.est_ack_nrs);
            check_flag("est_ack_demap", est_ack_demap, e.est_ack_demap);
            check_flag("mult_mem_en", mult_mem_en, e.mult_mem_en);
            check_flag("avg_mem_en", avg_mem_en, e.avg_mem_en);
            check_flag("valid_eqlz", valid_eqlz, e.valid_eqlz);
            check_flag("s_est", s_est, e.s_est);
            check_addr("addr_mem", `CH_EST_NRS_ADDR_W'(addr_mem), `CH_EST_NRS_ADDR_W'(e.addr_mem));
            check_addr("nrs_index_addr", `CH_EST_NRS_ADDR_W'(nrs_index_addr),
                       `CH_EST_NRS_ADDR_W'(e.nrs_index_addr));
            check_addr("rd_addr_nrs", rd_addr_nrs, e.rd_addr_nrs);
            check_col(col, e.col);
            check_sel("s_h1", s_h1, e.s_h1);
            check_sel("s_h2", s_h2, e.s_h2);
            if (est_ack_demap === 1'b1)
                windows_seen++;
            // window opens on the ready pulse with the class of the current v_shift
            if (e.est_ack_demap) begin
                win_left = SEQ;
                win_cls  = shift_class(v_shift);
                est_sel  = (win_cls % 2) == 1;
            end else if (win_left > 0) begin
                win_left--;
            end
            // burst position for the next cycle
            if (m_active) begin
                beats_done++;
                if (m_beat == 1) begin
                    m_active = 1'b0;
                    m_burst  = (m_burst + 1) % 4;
                end else begin
                    m_beat = 1;
                end
            end else if (demap_ready && nrs_gen_ready) begin
                m_active = 1'b1;
                m_beat   = 0;
            end
        end
    end

    // ================================================
    // stimulus
    // ================================================

    function automatic int rand_below(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[30:16]) % n;
    endfunction

    // random idle gap with at most one ready high, then one burst
    task automatic do_burst(input int gap, input bit rand_v);
        int r;
        repeat (gap) begin
            @(posedge clk);
            r = rand_below(4);
            demap_ready   <= (r == 1);
            nrs_gen_ready <= (r >= 2);
        end
        @(posedge clk);
        demap_ready   <= 1'b1;
        nrs_gen_ready <= 1'b1;
        if (rand_v)
            v_shift <= 3'(rand_below(8));
        do @(negedge clk); while (demap_read !== 1'b1);
        @(posedge clk);
        demap_ready   <= 1'b0;
        nrs_gen_ready <= 1'b0;
    endtask

    // four bursts, then wait for the estimate window to drain
    task automatic run_pair(input logic [2:0] v, input bit random_mode);
        if (!random_mode) begin
            @(posedge clk);
            v_shift <= v;
        end
        for (int b = 0; b < 4; b++)
            do_burst(random_mode ? rand_below(4) : 0, random_mode);
        do @(negedge clk); while (valid_eqlz !== 1'b1);
        do @(negedge clk); while (valid_eqlz !== 1'b0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
        test_win0 = windows_seen;
    endtask

    task automatic end_test(input int exp_windows);
        if (windows_seen - test_win0 != exp_windows) begin
            errors++;
            $display("%s expected %0d estimate windows but saw %0d", test_name,
                     exp_windows, windows_seen - test_win0);
        end
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, test_name, errors - test_err0);
        end
    endtask

    // hang guard
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still busy after %0d cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        v_shift       = 3'd0;
        lcg_state     = 32'd8209;
        m_burst       = 0;
        wait (rst === 1'b1);

        start_test("reset_idle");
        repeat (3) @(posedge clk);
        end_test(0);

        start_test("slot_pair");
        run_pair(3'd2, 1'b0);
        end_test(1);

        start_test("shift_sweep");
        for (int v = 0; v < 8; v++)
            run_pair(3'(v), 1'b0);
        end_test(8);

        start_test("random_gaps");
        for (int p = 0; p < RAND_PAIRS; p++)
            run_pair(3'd0, 1'b1);
        end_test(RAND_PAIRS);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clk_gen.sv
// testbench clock and active-low reset source, instanced once by the testbench top
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release lands after the edge, so the DUT sees reset on all of them
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule
